//--- heat_pkg.sv
`default_nettype none

package heat_pkg;

    // heat level 0..8
    typedef logic [3:0] level_t;

    // scanned row of the 8x8 matrix
    typedef logic [2:0] row_idx_t;

    // one row of column bits, also the row select pattern
    typedef logic [7:0] cols_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [1:0] {
        IDLE,
        STEP,
        HOLD,
        FROZEN
    } seq_state_t;

    localparam level_t LEVEL_MAX = 4'd8;

    // register map, byte addresses
    localparam apb_addr_t ADDR_CTRL   = 8'h00;
    localparam apb_addr_t ADDR_TARGET = 8'h04;
    localparam apb_addr_t ADDR_STATUS = 8'h08;

    // STATUS bit positions
    localparam int STATUS_DONE_BIT     = 4;
    localparam int STATUS_OVERHEAT_BIT = 5;

endpackage

`default_nettype wire

//--- heat_regs.sv
`timescale 1ns/1ps
`default_nettype none

module heat_regs (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire heat_pkg::apb_addr_t paddr,
    input  wire heat_pkg::apb_data_t pwdata,
    input  wire logic                temp,
    input  wire heat_pkg::level_t    level,
    input  wire logic                done,
    output heat_pkg::apb_data_t      prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     run,
    output heat_pkg::level_t         target,
    output logic                     overheat
);

    logic             temp_meta;
    logic             temp_sync;
    logic             access;
    logic             wr_access;
    logic             addr_hit;
    heat_pkg::level_t wr_target;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign pready    = 1'b1; // zero wait states

    always_comb
    begin
        case (paddr)
            heat_pkg::ADDR_CTRL,
            heat_pkg::ADDR_TARGET,
            heat_pkg::ADDR_STATUS: addr_hit = 1'b1;
            default:               addr_hit = 1'b0;
        endcase
    end

    assign pslverr = access & ~addr_hit;

    // values above LEVEL_MAX saturate
    assign wr_target = (pwdata[3:0] > heat_pkg::LEVEL_MAX) ? heat_pkg::LEVEL_MAX
                                                           : heat_pkg::level_t'(pwdata[3:0]);

    // two-flop synchronizer for the alarm input
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            temp_meta <= 1'b0;
            temp_sync <= 1'b0;
        end
        else
        begin
            temp_meta <= temp;
            temp_sync <= temp_meta;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            run    <= 1'b0;
            target <= '0;
        end
        else if (wr_access)
        begin
            if (paddr == heat_pkg::ADDR_CTRL)
                run <= pwdata[0];
            if (paddr == heat_pkg::ADDR_TARGET)
                target <= wr_target;
        end
    end

    // sticky flag, write-one clear refused while the alarm is still up
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            overheat <= 1'b0;
        else if (temp_sync)
            overheat <= 1'b1;
        else if (wr_access && paddr == heat_pkg::ADDR_STATUS
                 && pwdata[heat_pkg::STATUS_OVERHEAT_BIT])
            overheat <= 1'b0;
    end

    always_comb
    begin
        case (paddr)
            heat_pkg::ADDR_CTRL:   prdata = heat_pkg::apb_data_t'(run);
            heat_pkg::ADDR_TARGET: prdata = heat_pkg::apb_data_t'(target);
            heat_pkg::ADDR_STATUS: prdata = heat_pkg::apb_data_t'({overheat, done, level});
            default:               prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- heat_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module heat_sequencer #(
    parameter int STEP_DIV = 100000
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             run,
    input  wire heat_pkg::level_t target,
    input  wire logic             overheat,
    output heat_pkg::level_t      level,
    output logic                  done
);

    localparam int CNT_W = $clog2(STEP_DIV + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STEP_DIV - 1);

    heat_pkg::seq_state_t state;
    logic [CNT_W-1:0]     step_cnt;
    logic                 step_last;
    heat_pkg::level_t     level_step;

    assign step_last = (step_cnt == CNT_LAST);

    // one level toward the target, either direction
    assign level_step = (level < target) ? level + 4'd1 : level - 4'd1;

    assign done = (state == heat_pkg::HOLD);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= heat_pkg::IDLE;
            level    <= '0;
            step_cnt <= '0;
        end
        else if (!run)
        begin
            state    <= heat_pkg::IDLE;
            level    <= '0;
            step_cnt <= '0;
        end
        else
        begin
            case (state)
                heat_pkg::IDLE:
                begin
                    level    <= '0;
                    step_cnt <= '0;
                    state    <= (target == '0) ? heat_pkg::HOLD : heat_pkg::STEP;
                end
                heat_pkg::STEP:
                begin
                    if (overheat)
                        state <= heat_pkg::FROZEN; // counter keeps its phase
                    else if (level == target)
                    begin
                        state    <= heat_pkg::HOLD;
                        step_cnt <= '0;
                    end
                    else if (step_last)
                    begin
                        step_cnt <= '0;
                        level    <= level_step;
                        if (level_step == target)
                            state <= heat_pkg::HOLD;
                    end
                    else
                        step_cnt <= step_cnt + 1'b1;
                end
                heat_pkg::HOLD:
                begin
                    step_cnt <= '0;
                    // target moved, go after it at the step rate
                    if (level != target)
                        state <= overheat ? heat_pkg::FROZEN : heat_pkg::STEP;
                end
                heat_pkg::FROZEN:
                begin
                    if (!overheat)
                        state <= (level == target) ? heat_pkg::HOLD : heat_pkg::STEP;
                end
                default:
                    state <= heat_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan #(
    parameter int SCAN_DIV = 1000
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire heat_pkg::level_t level,
    input  wire logic             overheat,
    output heat_pkg::cols_t       row,
    output heat_pkg::cols_t       colg,
    output heat_pkg::cols_t       colr
);

    localparam int DIV_W = $clog2(SCAN_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

    logic [DIV_W-1:0]   div_cnt;
    logic               tick;
    heat_pkg::row_idx_t row_idx;
    heat_pkg::row_idx_t row_idx_nxt;
    heat_pkg::cols_t    row_nxt;
    heat_pkg::cols_t    gauge_nxt;

    // active-low one-hot row select
    function automatic heat_pkg::cols_t row_pattern(input heat_pkg::row_idx_t r);
        heat_pkg::cols_t pat;
        case (r)
            3'd0:    pat = 8'b1111_1110;
            3'd1:    pat = 8'b1111_1101;
            3'd2:    pat = 8'b1111_1011;
            3'd3:    pat = 8'b1111_0111;
            3'd4:    pat = 8'b1110_1111;
            3'd5:    pat = 8'b1101_1111;
            3'd6:    pat = 8'b1011_1111;
            default: pat = 8'b0111_1111;
        endcase
        return pat;
    endfunction

    // fill gauge, bottom rows light first
    // row r is lit when r >= 8 - level
    function automatic heat_pkg::cols_t gauge_cols(input heat_pkg::level_t lvl,
                                                   input heat_pkg::row_idx_t r);
        logic [4:0] sum;
        sum = {2'b00, r} + {1'b0, lvl}; // 5 bits so r + lvl cannot wrap
        return (sum >= 5'd8) ? 8'hFF : 8'h00;
    endfunction

    assign tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign row_idx_nxt = row_idx + 3'd1; // 7 wraps to 0
    assign row_nxt     = row_pattern(row_idx_nxt);
    assign gauge_nxt   = gauge_cols(level, row_idx_nxt);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (tick)
            row_idx <= row_idx_nxt;
    end

    // row and both colour planes change on the same edge
    // so no row is ever shown with its neighbour's columns
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'b1111_1110;
            colg <= '0;
            colr <= '0;
        end
        else if (tick)
        begin
            row  <= row_nxt;
            colg <= gauge_nxt;
            colr <= overheat ? gauge_nxt : 8'h00; // red overlay
        end
    end

endmodule

`default_nettype wire

//--- heat_panel_top.sv
`timescale 1ns/1ps
`default_nettype none

module heat_panel_top #(
    parameter int SCAN_DIV = 1000,
    parameter int STEP_DIV = 100000
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire heat_pkg::apb_addr_t paddr,
    input  wire heat_pkg::apb_data_t pwdata,
    output heat_pkg::apb_data_t      prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  wire logic                temp,
    output heat_pkg::cols_t          row,
    output heat_pkg::cols_t          colg,
    output heat_pkg::cols_t          colr
);

    logic             run;
    logic             overheat;
    logic             done;
    heat_pkg::level_t target;
    heat_pkg::level_t level;

    heat_regs i_heat_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .temp     (temp),
        .level    (level),
        .done     (done),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .run      (run),
        .target   (target),
        .overheat (overheat)
    );

    heat_sequencer #(
        .STEP_DIV (STEP_DIV)
    ) i_heat_sequencer (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .target   (target),
        .overheat (overheat),
        .level    (level),
        .done     (done)
    );

    matrix_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) i_matrix_scan (
        .clk      (clk),
        .rst      (rst),
        .level    (level),
        .overheat (overheat),
        .row      (row),
        .colg     (colg),
        .colr     (colr)
    );

endmodule

`default_nettype wire

//--- heat_panel_props.sv
`timescale 1ns/1ps
`default_nettype none

module heat_panel_props (
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            psel,
    input wire logic            penable,
    input wire logic            pready,
    input wire logic            pslverr,
    input wire heat_pkg::cols_t row,
    input wire heat_pkg::cols_t colg,
    input wire heat_pkg::cols_t colr
);

    int unsigned fail_cnt = 0; // failed property count

    // active-low one-hot row select
    row_one_low: assert property (@(posedge clk) disable iff (rst) $onehot(~row))
    else
    begin
        $error("row 0x%h does not select exactly one row", row);
        fail_cnt++;
    end

    red_follows_green: assert property (@(posedge clk) disable iff (rst)
        colr == 8'h00 || colr == colg)
    else
    begin
        $error("colr 0x%h is neither zero nor colg 0x%h", colr, colg);
        fail_cnt++;
    end

    ready_high: assert property (@(posedge clk) disable iff (rst) pready)
    else
    begin
        $error("pready went low");
        fail_cnt++;
    end

    slverr_access_only: assert property (@(posedge clk) disable iff (rst)
        !(psel && penable) |-> !pslverr)
    else
    begin
        $error("pslverr high outside the access phase");
        fail_cnt++;
    end

endmodule

bind heat_panel_top heat_panel_props i_heat_panel_props (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .row     (row),
    .colg    (colg),
    .colr    (colr)
);

`default_nettype wire

//--- heat_panel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module heat_panel_tb;

    localparam int SCAN_DIV = 4;
    localparam int STEP_DIV = 64;
    localparam int POLL_LIMIT = 2000; // cycles

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    heat_pkg::apb_addr_t paddr;
    heat_pkg::apb_data_t pwdata;
    heat_pkg::apb_data_t prdata;
    logic                pready;
    logic                pslverr;
    logic                temp;
    heat_pkg::cols_t     row;
    heat_pkg::cols_t     colg;
    heat_pkg::cols_t     colr;

    logic                check_en;  // level known stable
    heat_pkg::level_t    exp_level;
    logic                exp_oh;
    heat_pkg::cols_t     exp_colg;
    heat_pkg::cols_t     prev_row;
    int                  still;
    int                  rows_checked = 0;
    int                  cycle_cnt = 0;

    heat_panel_top #(.SCAN_DIV(SCAN_DIV), .STEP_DIV(STEP_DIV)) i_heat_panel_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // row r lit when r >= 8 - level
    function automatic heat_pkg::cols_t gauge(input heat_pkg::level_t lvl, input int r);
        if (r >= 8 - int'(lvl))
            return 8'hFF;
        return 8'h00;
    endfunction

    function automatic int row_of(input heat_pkg::cols_t pat);
        int idx;
        idx = -1;
        for (int i = 0; i < 8; i++)
            if (!pat[i])
                idx = i;
        return idx;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic write_reg(input heat_pkg::apb_addr_t addr, input heat_pkg::apb_data_t data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        assert (!pslverr)
            else stop_with_error($sformatf("error pslverr: got 0x1 expected 0x0 at 0x%h", addr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input heat_pkg::apb_addr_t addr, input logic exp_err,
                            output heat_pkg::apb_data_t data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(negedge clk);
        penable = 1'b1;
        #1; // prdata settled in the access phase
        data = prdata;
        assert (pslverr == exp_err)
            else stop_with_error($sformatf("error pslverr: got 0x%h expected 0x%h at 0x%h",
                                           pslverr, exp_err, addr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_status(output heat_pkg::level_t lvl, output logic dn, output logic oh);
        heat_pkg::apb_data_t data;
        read_reg(heat_pkg::ADDR_STATUS, 1'b0, data);
        lvl = data[3:0];
        dn  = data[4];
        oh  = data[5];
    endtask

    // repeat STATUS reads until the given bit is set
    task automatic poll_status(input int bit_pos, input string what,
                               output heat_pkg::level_t lvl);
        heat_pkg::apb_data_t data;
        int                  start;
        start = cycle_cnt;
        read_reg(heat_pkg::ADDR_STATUS, 1'b0, data);
        while (!data[bit_pos])
        begin
            if (cycle_cnt - start > POLL_LIMIT)
                stop_with_error({"timeout waiting for ", what, " in STATUS"});
            read_reg(heat_pkg::ADDR_STATUS, 1'b0, data);
        end
        lvl = data[3:0];
    endtask

    task automatic watch_frame();
        int start;
        int waited;
        start  = rows_checked;
        waited = 0;
        while (rows_checked < start + 8)
        begin
            @(negedge clk);
            waited++;
            if (waited > 12 * SCAN_DIV)
                stop_with_error("timeout waiting for a checked frame of eight rows");
        end
    endtask

    // row changes picked up on the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            prev_row = row;
            still    = 0;
        end
        else if (row != prev_row)
        begin
            assert (row == {prev_row[6:0], prev_row[7]})
                else stop_with_error($sformatf("error row: got 0x%h expected 0x%h",
                                               row, {prev_row[6:0], prev_row[7]}));
            if (check_en)
            begin
                exp_colg = gauge(exp_level, row_of(row));
                assert (colg == exp_colg)
                    else stop_with_error($sformatf("error colg: got 0x%h expected 0x%h row 0x%h",
                                                   colg, exp_colg, row));
                assert (colr == (exp_oh ? exp_colg : 8'h00))
                    else stop_with_error($sformatf("error colr: got 0x%h expected 0x%h row 0x%h",
                                                   colr, exp_oh ? exp_colg : 8'h00, row));
                rows_checked++;
            end
            prev_row = row;
            still    = 0;
        end
        else
        begin
            still++;
            if (still > 2 * SCAN_DIV)
                stop_with_error("row scan stalled, row did not advance in time");
        end
    end

    // bound port properties
    always @(negedge clk)
    begin
        assert (i_heat_panel_top.i_heat_panel_props.fail_cnt == 0)
            else stop_with_error("a bound property on the DUT ports failed");
    end

    initial
    begin
        heat_pkg::apb_data_t data;
        heat_pkg::apb_data_t exp_data;
        heat_pkg::level_t    lvl;
        heat_pkg::level_t    lvl2;
        heat_pkg::level_t    tgt;
        logic                dn;
        logic                oh;
        void'($urandom(76612));
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        temp      = 1'b0;
        check_en  = 1'b0;
        exp_level = '0;
        exp_oh    = 1'b0;
        idle_cycles(10);
        rst = 1'b0;

        assert (row == 8'hFE && colg == 8'h00 && colr == 8'h00)
            else stop_with_error($sformatf("error row/colg/colr after reset: 0x%h 0x%h 0x%h",
                                           row, colg, colr));
        for (int a = 0; a < 12; a += 4)
        begin
            read_reg(heat_pkg::apb_addr_t'(a), 1'b0, data);
            assert (data == '0)
                else stop_with_error($sformatf("error prdata: got 0x%h expected 0x0 at 0x%h",
                                               data, a));
        end
        for (int i = 0; i < 8; i++)
        begin
            data = (i == 0) ? 32'hF : 32'($urandom_range(15, 0)); // first one always clamps
            write_reg(heat_pkg::ADDR_TARGET, data);
            exp_data = (data > 8) ? 32'd8 : data;
            read_reg(heat_pkg::ADDR_TARGET, 1'b0, data);
            assert (data == exp_data)
                else stop_with_error($sformatf("error target: got 0x%h expected 0x%h",
                                               data, exp_data));
        end
        read_reg(8'h0C, 1'b1, data); // unmapped

        // blank gauge while idle
        check_en = 1'b1;
        watch_frame();
        watch_frame();

        check_en = 1'b0;
        tgt = heat_pkg::level_t'($urandom_range(8, 5));
        write_reg(heat_pkg::ADDR_TARGET, heat_pkg::apb_data_t'(tgt));
        write_reg(heat_pkg::ADDR_CTRL, 32'h1);
        poll_status(heat_pkg::STATUS_DONE_BIT, "done", lvl);
        assert (lvl == tgt)
            else stop_with_error($sformatf("error level: got 0x%h expected 0x%h", lvl, tgt));
        exp_level = lvl;
        check_en  = 1'b1;
        watch_frame();

        // restart and raise the alarm mid-ramp
        check_en = 1'b0;
        write_reg(heat_pkg::ADDR_CTRL, 32'h0);
        tgt = heat_pkg::level_t'($urandom_range(8, 5));
        write_reg(heat_pkg::ADDR_TARGET, heat_pkg::apb_data_t'(tgt));
        write_reg(heat_pkg::ADDR_CTRL, 32'h1);
        idle_cycles(STEP_DIV + int'($urandom_range(2 * STEP_DIV, 0)));
        temp = 1'b1;
        poll_status(heat_pkg::STATUS_OVERHEAT_BIT, "overheat", lvl);
        idle_cycles(3 * STEP_DIV);
        read_status(lvl2, dn, oh);
        assert (lvl2 == lvl && lvl < tgt)
            else stop_with_error($sformatf("error level while frozen: got 0x%h expected 0x%h",
                                           lvl2, lvl));
        exp_level = lvl2;
        exp_oh    = 1'b1;
        check_en  = 1'b1;
        watch_frame();
        write_reg(heat_pkg::ADDR_STATUS, 32'h20);
        read_status(lvl, dn, oh);
        assert (oh)
            else stop_with_error("error overheat: got 0x0 expected 0x1 with temp still high");
        check_en = 1'b0;
        temp     = 1'b0;
        idle_cycles(4); // synchronizer drains
        write_reg(heat_pkg::ADDR_STATUS, 32'h20);
        read_status(lvl, dn, oh);
        assert (!oh)
            else stop_with_error("error overheat: got 0x1 expected 0x0 after clear");
        poll_status(heat_pkg::STATUS_DONE_BIT, "done after overheat", lvl);
        assert (lvl == tgt)
            else stop_with_error($sformatf("error level: got 0x%h expected 0x%h", lvl, tgt));
        exp_level = lvl;
        exp_oh    = 1'b0;
        check_en  = 1'b1;
        watch_frame();

        check_en = 1'b0;
        write_reg(heat_pkg::ADDR_CTRL, 32'h0);
        read_status(lvl, dn, oh);
        assert (lvl == '0 && !dn)
            else stop_with_error($sformatf("error level/done after stop: got 0x%h 0x%h",
                                           lvl, dn));
        exp_level = '0;
        check_en  = 1'b1;
        watch_frame();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
heat_pkg.sv
heat_regs.sv
heat_sequencer.sv
matrix_scan.sv
heat_panel_top.sv
heat_panel_props.sv
heat_panel_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module heat_panel_tb -f all.f \
    -o heat_panel_sim && ./obj_dir/heat_panel_sim || exit 1
